/* src/sdp_rdma_eg_consts.svh */
// widths and mode codes for the rdma egress stage, included by the package and every rtl module
`ifndef SDP_RDMA_EG_CONSTS_SVH
`define SDP_RDMA_EG_CONSTS_SVH

// ======================================================================
// datapath geometry
// ======================================================================

// bits per atom
`define RDMA_EG_ATOM_W 32

// atoms per dma return word
`define RDMA_EG_ATOMS 4

// ======================================================================
// counter widths and configuration codes
// ======================================================================

// context entry size field, atoms minus one
`define RDMA_EG_CQ_SIZE_W 15

// programmed layer atom count
`define RDMA_EG_LAYER_W 16

// data use register encoding
`define RDMA_EG_USE_MUL 2'd0
`define RDMA_EG_USE_ALU 2'd1
`define RDMA_EG_USE_BOTH 2'd2

`endif

/* src/sdp_rdma_eg_pkg.sv */
// shared payload and mode types for the rdma egress stage, imported by every rtl module
`include "sdp_rdma_eg_consts.svh"

package sdp_rdma_eg_pkg;

  // one atom of payload
  typedef logic [`RDMA_EG_ATOM_W-1:0] atom_t;

  // one bit per atom of a word
  typedef logic [`RDMA_EG_ATOMS-1:0] atom_mask_t;

  // full dma return word, atom 0 in the low bits
  typedef logic [`RDMA_EG_ATOMS*`RDMA_EG_ATOM_W-1:0] mem_word_t;

  // which consumers take the data
  typedef enum logic [1:0] {
    mul_only = `RDMA_EG_USE_MUL,
    alu_only = `RDMA_EG_USE_ALU,
    both     = `RDMA_EG_USE_BOTH
  } data_use_e;

  // element size inside an atom
  typedef enum logic {
    size_1byte = 1'b0,
    size_2byte = 1'b1
  } data_size_e;

  // layer atom count, N means N+1 atoms
  typedef logic [`RDMA_EG_LAYER_W-1:0] layer_cnt_t;

endpackage

/* src/rdma_eg_ctrl.sv */
// egress control: mode decode, context queue beat counting and the layer done handshake
`timescale 1ns/1ps
`include "sdp_rdma_eg_consts.svh"

module rdma_eg_ctrl import sdp_rdma_eg_pkg::*; (
  input  logic                                nvdla_core_clk,
  input  logic                                nvdla_core_rstn,
  input  data_use_e                           data_use,
  input  data_size_e                          data_size,
  input  logic [`RDMA_EG_CQ_SIZE_W-1:0]       cq_size,
  input  logic                                cq_valid,
  input  logic                                word_take,
  input  logic [$clog2(`RDMA_EG_ATOMS+1)-1:0] word_atoms,
  input  logic                                op_load,
  input  logic                                alu_layer_end,
  input  logic                                mul_layer_end,
  output logic                                cq_ready,
  output logic                                word_take_ok,
  output logic                                alu_en,
  output logic                                mul_en,
  output logic                                use_both,
  output logic                                size_2byte,
  output logic                                eg_done
);

  // one extra bit so cq_size+1 fits
  localparam int CNT_W = `RDMA_EG_CQ_SIZE_W + 1;

  logic [CNT_W-1:0] beat_count;
  logic [CNT_W-1:0] beat_count_nxt;
  logic [CNT_W-1:0] beat_size;
  logic             is_last_beat;
  logic             alu_layer_done;
  logic             mul_layer_done;
  logic             layer_done;

  // ======================================================================
  // configuration decode
  // ======================================================================
  assign alu_en     = (data_use == alu_only) || (data_use == both);
  assign mul_en     = (data_use == mul_only) || (data_use == both);
  assign use_both   = (data_use == both);
  // port name hides the enum literal, so scope it
  assign size_2byte = (data_size == sdp_rdma_eg_pkg::size_2byte);

  // ======================================================================
  // context queue
  // ======================================================================
  // return data must always have a context entry waiting
  assign word_take_ok = cq_valid;

  // entry size is atoms minus one
  assign beat_size      = CNT_W'(cq_size) + 1'b1;
  assign beat_count_nxt = beat_count + CNT_W'(word_atoms);
  assign is_last_beat   = (beat_count_nxt == beat_size);

  // pop the entry on the beat that completes it
  assign cq_ready = word_take & is_last_beat;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      beat_count <= '0;
    end else if (word_take) begin
      if (is_last_beat) begin
        beat_count <= '0;
      end else begin
        beat_count <= beat_count_nxt;
      end
    end
  end

  // ======================================================================
  // layer done
  // ======================================================================
  // disabled stream counts as done from op_load on
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      alu_layer_done <= 1'b0;
      mul_layer_done <= 1'b0;
    end else begin
      if (op_load) begin
        alu_layer_done <= !alu_en;
      end else if (alu_layer_end) begin
        alu_layer_done <= 1'b1;
      end else if (layer_done) begin
        alu_layer_done <= 1'b0;
      end
      if (op_load) begin
        mul_layer_done <= !mul_en;
      end else if (mul_layer_end) begin
        mul_layer_done <= 1'b1;
      end else if (layer_done) begin
        mul_layer_done <= 1'b0;
      end
    end
  end

  assign layer_done = alu_layer_done & mul_layer_done;

  // flags clear on the same edge, so this is a single pulse
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      eg_done <= 1'b0;
    end else begin
      eg_done <= layer_done;
    end
  end

endmodule

/* src/rdma_eg_route.sv */
// egress router: takes dma words and forwards or splits their atoms to the alu and mul streams
`timescale 1ns/1ps
`include "sdp_rdma_eg_consts.svh"

module rdma_eg_route import sdp_rdma_eg_pkg::*; (
  input  mem_word_t                           dma_rsp_data,
  input  atom_mask_t                          dma_rsp_mask,
  input  logic                                dma_rsp_valid,
  input  logic                                word_take_ok,
  input  logic                                alu_en,
  input  logic                                mul_en,
  input  logic                                use_both,
  input  logic                                size_2byte,
  input  logic                                alu_in_ready,
  input  logic                                mul_in_ready,
  output logic                                dma_rsp_ready,
  output logic                                dma_cdt_pop,
  output logic                                word_take,
  output logic [$clog2(`RDMA_EG_ATOMS+1)-1:0] word_atoms,
  output mem_word_t                           alu_in_data,
  output atom_mask_t                          alu_in_mask,
  output logic                                alu_in_valid,
  output mem_word_t                           mul_in_data,
  output atom_mask_t                          mul_in_mask,
  output logic                                mul_in_valid
);

  localparam int AW         = `RDMA_EG_ATOM_W;
  localparam int ATOM_CNT_W = $clog2(`RDMA_EG_ATOMS + 1);

  mem_word_t  both_alu_data;
  mem_word_t  both_mul_data;
  atom_mask_t both_mask;

  // pick even or odd elements of an atom pair with the lower atom first
  function automatic atom_t split_pair(input atom_t lo, input atom_t hi,
                                       input logic odd, input logic half);
    logic [2*AW-1:0] pair;
    atom_t           res;
    pair = {hi, lo};
    res  = '0;
    if (half) begin
      for (int j = 0; j < AW / 16; j++) begin
        res[16*j +: 16] = pair[32*j + 16*odd +: 16];
      end
    end else begin
      for (int j = 0; j < AW / 8; j++) begin
        res[8*j +: 8] = pair[16*j + 8*odd +: 8];
      end
    end
    return res;
  endfunction

  // ======================================================================
  // handshake takes all enabled streams or none
  // ======================================================================
  assign dma_rsp_ready = word_take_ok & (!alu_en | alu_in_ready) & (!mul_en | mul_in_ready);
  assign word_take     = dma_rsp_valid & dma_rsp_ready;
  assign dma_cdt_pop   = word_take;

  // each stream valid waits on the other stream's ready
  assign alu_in_valid = alu_en & dma_rsp_valid & word_take_ok & (!mul_en | mul_in_ready);
  assign mul_in_valid = mul_en & dma_rsp_valid & word_take_ok & (!alu_en | alu_in_ready);

  // atoms carried by this beat
  always_comb begin
    word_atoms = '0;
    for (int i = 0; i < `RDMA_EG_ATOMS; i++) begin
      word_atoms = word_atoms + ATOM_CNT_W'(dma_rsp_mask[i]);
    end
  end

  // ======================================================================
  // both mode split
  // ======================================================================
  // pair k feeds output atom k and the upper half of the word stays empty
  always_comb begin
    both_alu_data = '0;
    both_mul_data = '0;
    both_mask     = '0;
    for (int k = 0; k < `RDMA_EG_ATOMS / 2; k++) begin
      both_alu_data[AW*k +: AW] = split_pair(dma_rsp_data[AW*2*k +: AW],
                                             dma_rsp_data[AW*(2*k+1) +: AW], 1'b0, size_2byte);
      both_mul_data[AW*k +: AW] = split_pair(dma_rsp_data[AW*2*k +: AW],
                                             dma_rsp_data[AW*(2*k+1) +: AW], 1'b1, size_2byte);
      both_mask[k] = dma_rsp_mask[2*k];
    end
  end

  // single mode passes the word through
  assign alu_in_data = use_both ? both_alu_data : dma_rsp_data;
  assign mul_in_data = use_both ? both_mul_data : dma_rsp_data;
  assign alu_in_mask = use_both ? both_mask : dma_rsp_mask;
  assign mul_in_mask = use_both ? both_mask : dma_rsp_mask;

endmodule

/* src/rdma_eg_stream.sv */
// per-consumer stream: one word buffer, masked atoms out one per cycle, layer end counting
`timescale 1ns/1ps
`include "sdp_rdma_eg_consts.svh"

module rdma_eg_stream import sdp_rdma_eg_pkg::*; (
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  mem_word_t  in_data,
  input  atom_mask_t in_mask,
  input  logic       in_valid,
  input  layer_cnt_t layer_atoms,
  input  logic       op_load,
  input  logic       out_ready,
  output logic       in_ready,
  output atom_t      out_pd,
  output logic       out_last,
  output logic       out_valid,
  output logic       layer_end
);

  localparam int AW    = `RDMA_EG_ATOM_W;
  localparam int IDX_W = $clog2(`RDMA_EG_ATOMS);

  mem_word_t        buf_data;
  atom_mask_t       buf_mask;
  atom_mask_t       buf_mask_nxt;
  logic [IDX_W-1:0] sel;
  logic             out_take;
  layer_cnt_t       atom_cnt;

  // ======================================================================
  // word buffer
  // ======================================================================
  // buffer is empty once every masked atom is gone
  assign in_ready  = (buf_mask == '0);
  assign out_valid = (buf_mask != '0);
  assign out_take  = out_valid & out_ready;

  // lowest remaining atom goes first
  always_comb begin
    sel = '0;
    for (int i = `RDMA_EG_ATOMS - 1; i >= 0; i--) begin
      if (buf_mask[i]) begin
        sel = IDX_W'(i);
      end
    end
  end

  // retire the selected atom
  always_comb begin
    buf_mask_nxt      = buf_mask;
    buf_mask_nxt[sel] = 1'b0;
  end

  assign out_pd = buf_data[AW*sel +: AW];

  // remaining mask is the control state
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      buf_mask <= '0;
    end else if (in_valid && in_ready) begin
      buf_mask <= in_mask;
    end else if (out_take) begin
      buf_mask <= buf_mask_nxt;
    end
  end

  // payload held until the next load
  always_ff @(posedge nvdla_core_clk) begin
    if (in_valid && in_ready) begin
      buf_data <= in_data;
    end
  end

  // ======================================================================
  // layer end counting
  // ======================================================================
  // last atom of the layer when the count reaches layer_atoms
  assign out_last  = (atom_cnt == layer_atoms);
  assign layer_end = out_take & out_last;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      atom_cnt <= '0;
    end else if (op_load) begin
      atom_cnt <= '0;
    end else if (out_take) begin
      // wrap for the next layer
      if (out_last) begin
        atom_cnt <= '0;
      end else begin
        atom_cnt <= atom_cnt + 1'b1;
      end
    end
  end

endmodule

/* src/sdp_rdma_eg.sv */
// top of the rdma egress stage, connects control, router and the alu and mul streams
`timescale 1ns/1ps
`include "sdp_rdma_eg_consts.svh"

module sdp_rdma_eg import sdp_rdma_eg_pkg::*; (
  input  logic                          nvdla_core_clk,
  input  logic                          nvdla_core_rstn,
  // dma return
  input  mem_word_t                     dma_rsp_data,
  input  atom_mask_t                    dma_rsp_mask,
  input  logic                          dma_rsp_valid,
  output logic                          dma_rsp_ready,
  output logic                          dma_cdt_pop,
  // context queue
  input  logic [`RDMA_EG_CQ_SIZE_W-1:0] cq_size,
  input  logic                          cq_cube_end,
  input  logic                          cq_valid,
  output logic                          cq_ready,
  // consumer streams
  output atom_t                         alu_pd,
  output logic                          alu_last,
  output logic                          alu_valid,
  input  logic                          alu_ready,
  output atom_t                         mul_pd,
  output logic                          mul_last,
  output logic                          mul_valid,
  input  logic                          mul_ready,
  // configuration and completion
  input  data_use_e                     data_use,
  input  data_size_e                    data_size,
  input  layer_cnt_t                    layer_atoms,
  input  logic                          op_load,
  output logic                          eg_done
);

  // cq_cube_end rides with the entry, layer end comes from the stream counts

  logic                                word_take_ok;
  logic                                word_take;
  logic [$clog2(`RDMA_EG_ATOMS+1)-1:0] word_atoms;
  logic                                alu_en;
  logic                                mul_en;
  logic                                use_both;
  logic                                size_2byte;
  mem_word_t                           alu_in_data;
  atom_mask_t                          alu_in_mask;
  logic                                alu_in_valid;
  logic                                alu_in_ready;
  mem_word_t                           mul_in_data;
  atom_mask_t                          mul_in_mask;
  logic                                mul_in_valid;
  logic                                mul_in_ready;
  logic                                alu_layer_end;
  logic                                mul_layer_end;

  rdma_eg_ctrl u_ctrl (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .data_use       (data_use),
    .data_size      (data_size),
    .cq_size        (cq_size),
    .cq_valid       (cq_valid),
    .word_take      (word_take),
    .word_atoms     (word_atoms),
    .op_load        (op_load),
    .alu_layer_end  (alu_layer_end),
    .mul_layer_end  (mul_layer_end),
    .cq_ready       (cq_ready),
    .word_take_ok   (word_take_ok),
    .alu_en         (alu_en),
    .mul_en         (mul_en),
    .use_both       (use_both),
    .size_2byte     (size_2byte),
    .eg_done        (eg_done)
  );

  rdma_eg_route u_route (
    .dma_rsp_data (dma_rsp_data),
    .dma_rsp_mask (dma_rsp_mask),
    .dma_rsp_valid(dma_rsp_valid),
    .word_take_ok (word_take_ok),
    .alu_en       (alu_en),
    .mul_en       (mul_en),
    .use_both     (use_both),
    .size_2byte   (size_2byte),
    .alu_in_ready (alu_in_ready),
    .mul_in_ready (mul_in_ready),
    .dma_rsp_ready(dma_rsp_ready),
    .dma_cdt_pop  (dma_cdt_pop),
    .word_take    (word_take),
    .word_atoms   (word_atoms),
    .alu_in_data  (alu_in_data),
    .alu_in_mask  (alu_in_mask),
    .alu_in_valid (alu_in_valid),
    .mul_in_data  (mul_in_data),
    .mul_in_mask  (mul_in_mask),
    .mul_in_valid (mul_in_valid)
  );

  // ======================================================================
  // consumer streams
  // ======================================================================
  rdma_eg_stream u_alu (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .in_data        (alu_in_data),
    .in_mask        (alu_in_mask),
    .in_valid       (alu_in_valid),
    .layer_atoms    (layer_atoms),
    .op_load        (op_load),
    .out_ready      (alu_ready),
    .in_ready       (alu_in_ready),
    .out_pd         (alu_pd),
    .out_last       (alu_last),
    .out_valid      (alu_valid),
    .layer_end      (alu_layer_end)
  );

  rdma_eg_stream u_mul (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .in_data        (mul_in_data),
    .in_mask        (mul_in_mask),
    .in_valid       (mul_in_valid),
    .layer_atoms    (layer_atoms),
    .op_load        (op_load),
    .out_ready      (mul_ready),
    .in_ready       (mul_in_ready),
    .out_pd         (mul_pd),
    .out_last       (mul_last),
    .out_valid      (mul_valid),
    .layer_end      (mul_layer_end)
  );

endmodule

/* bench/sdp_rdma_eg_sva.sv */
// protocol assertions for the rdma egress top level, attached by bind to every instance
`timescale 1ns/1ps

module sdp_rdma_eg_sva import sdp_rdma_eg_pkg::*; (
  input logic  nvdla_core_clk,
  input logic  nvdla_core_rstn,
  input logic  dma_rsp_valid,
  input logic  dma_rsp_ready,
  input logic  dma_cdt_pop,
  input logic  cq_valid,
  input logic  cq_ready,
  input atom_t alu_pd,
  input logic  alu_last,
  input logic  alu_valid,
  input logic  alu_ready,
  input atom_t mul_pd,
  input logic  mul_last,
  input logic  mul_valid,
  input logic  mul_ready,
  input logic  eg_done
);

  // failed assertions so far
  int fail_count = 0;

  // ======================================================================
  // consumer streams hold under stall
  // ======================================================================
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    alu_valid && !alu_ready |=> alu_valid && $stable(alu_pd) && $stable(alu_last))
    else begin
      fail_count++;
      $error("alu stream changed while stalled");
    end

  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    mul_valid && !mul_ready |=> mul_valid && $stable(mul_pd) && $stable(mul_last))
    else begin
      fail_count++;
      $error("mul stream changed while stalled");
    end

  // ======================================================================
  // dma side
  // ======================================================================
  assert property (@(posedge nvdla_core_clk)
    dma_cdt_pop == (dma_rsp_valid && dma_rsp_ready))
    else begin
      fail_count++;
      $error("credit pop differs from the dma transfer");
    end

  // words need a context entry
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dma_rsp_valid && dma_rsp_ready |-> cq_valid)
    else begin
      fail_count++;
      $error("dma transfer with no context entry");
    end

  // ======================================================================
  // reset and completion
  // ======================================================================
  assert property (@(posedge nvdla_core_clk)
    !nvdla_core_rstn |-> !alu_valid && !mul_valid && !eg_done && !cq_ready && !dma_cdt_pop)
    else begin
      fail_count++;
      $error("output active during reset");
    end

  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    eg_done |=> !eg_done)
    else begin
      fail_count++;
      $error("eg_done high two cycles running");
    end

endmodule

bind sdp_rdma_eg sdp_rdma_eg_sva u_sva (
  .nvdla_core_clk (nvdla_core_clk),
  .nvdla_core_rstn(nvdla_core_rstn),
  .dma_rsp_valid  (dma_rsp_valid),
  .dma_rsp_ready  (dma_rsp_ready),
  .dma_cdt_pop    (dma_cdt_pop),
  .cq_valid       (cq_valid),
  .cq_ready       (cq_ready),
  .alu_pd         (alu_pd),
  .alu_last       (alu_last),
  .alu_valid      (alu_valid),
  .alu_ready      (alu_ready),
  .mul_pd         (mul_pd),
  .mul_last       (mul_last),
  .mul_valid      (mul_valid),
  .mul_ready      (mul_ready),
  .eg_done        (eg_done)
);

/* bench/sdp_rdma_eg_tb.sv */
// testbench for the rdma egress stage, runs seeded random layers against an expected atom model
`timescale 1ns/1ps
`include "sdp_rdma_eg_consts.svh"

module sdp_rdma_eg_tb import sdp_rdma_eg_pkg::*; ();

  localparam int AW        = `RDMA_EG_ATOM_W;
  localparam int CQ_W      = `RDMA_EG_CQ_SIZE_W;
  localparam int N_REQS    = 6;
  localparam int MAX_BEATS = 3;
  localparam int N_LAYERS  = 8;
  // seven cycles for every atom the layers can carry, about 4000 cycles
  localparam int TIMEOUT_CYCLES = N_LAYERS * N_REQS * MAX_BEATS * `RDMA_EG_ATOMS * 7;

  logic nvdla_core_clk;
  logic nvdla_core_rstn;
  mem_word_t dma_rsp_data;
  atom_mask_t dma_rsp_mask;
  logic dma_rsp_valid;
  logic dma_rsp_ready;
  logic dma_cdt_pop;
  logic [CQ_W-1:0] cq_size;
  logic cq_cube_end;
  logic cq_valid;
  logic cq_ready;
  atom_t alu_pd;
  atom_t mul_pd;
  logic alu_last;
  logic alu_valid;
  logic alu_ready;
  logic mul_last;
  logic mul_valid;
  logic mul_ready;
  data_use_e data_use;
  data_size_e data_size;
  layer_cnt_t layer_atoms;
  logic op_load;
  logic eg_done;

  // expected atoms and last flags per stream, in emission order
  atom_t exp_alu[$];
  atom_t exp_mul[$];
  logic exp_alu_last[$];
  logic exp_mul_last[$];
  int alu_cnt;
  int mul_cnt;
  int value_errors;
  int other_errors;
  int sva_errors;
  int cycles;
  int words_sent;
  int pops_seen;
  int done_seen;

  sdp_rdma_eg sdp_rdma_eg_inst (.*);

  always #50 nvdla_core_clk = ~nvdla_core_clk;

  // ======================================================================
  // reference model
  // ======================================================================
  // elements count up from the low byte of lo and odd picks the odd ones
  function automatic atom_t pick_elems(input atom_t lo, input atom_t hi,
                                       input bit odd, input bit half);
    logic [2*AW-1:0] pair;
    atom_t           res;
    int              esz;
    pair = {hi, lo};
    esz  = half ? 16 : 8;
    res  = '0;
    for (int j = 0; j < AW / esz; j++) begin
      for (int b = 0; b < esz; b++) begin
        res[j*esz + b] = pair[(2*j + int'(odd))*esz + b];
      end
    end
    return res;
  endfunction

  // last flag on atom layer_atoms+1 since op_load
  task automatic queue_atom(input bit to_alu, input atom_t a);
    bit last;
    if (to_alu) begin
      last = (alu_cnt == int'(layer_atoms));
      exp_alu.push_back(a);
      exp_alu_last.push_back(last);
      alu_cnt = last ? 0 : alu_cnt + 1;
    end else begin
      last = (mul_cnt == int'(layer_atoms));
      exp_mul.push_back(a);
      exp_mul_last.push_back(last);
      mul_cnt = last ? 0 : mul_cnt + 1;
    end
  endtask

  task automatic push_word(input mem_word_t data, input atom_mask_t mask);
    atom_t lo;
    atom_t hi;
    for (int i = 0; i < `RDMA_EG_ATOMS; i++) begin
      if (data_use != both && mask[i]) begin
        queue_atom(data_use == alu_only, data[AW*i +: AW]);
      end else if (data_use == both && i % 2 == 0 && mask[i]) begin
        lo = data[AW*i +: AW];
        hi = data[AW*(i+1) +: AW];
        // even elements feed alu, odd ones mul
        queue_atom(1'b1, pick_elems(lo, hi, 1'b0, data_size == size_2byte));
        queue_atom(1'b0, pick_elems(lo, hi, 1'b1, data_size == size_2byte));
      end
    end
  endtask

  // ======================================================================
  // output checks
  // ======================================================================
  task automatic check_stream(input string name, input logic valid, input logic ready,
                              input atom_t pd, input logic last,
                              ref atom_t exp_pd[$], ref logic exp_last[$]);
    atom_t want_pd;
    logic  want_last;
    if (exp_pd.size() == 0) begin
      assert (!valid) else begin
        other_errors++;
        $display("%0t ns: %s stream raised valid with no atom expected", $time, name);
      end
    end else if (valid && ready) begin
      want_pd   = exp_pd.pop_front();
      want_last = exp_last.pop_front();
      assert (pd === want_pd) else begin
        value_errors++;
        $display("[FAIL] %0t ns %s_pd expected %h got %h", $time, name, want_pd, pd);
      end
      assert (last === want_last) else begin
        value_errors++;
        $display("[FAIL] %0t ns %s_last expected %0b got %0b", $time, name, want_last, last);
      end
    end
  endtask

  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      check_stream("alu", alu_valid, alu_ready, alu_pd, alu_last, exp_alu, exp_alu_last);
      check_stream("mul", mul_valid, mul_ready, mul_pd, mul_last, exp_mul, exp_mul_last);
      if (dma_cdt_pop) pops_seen++;
      assert (!cq_ready || (dma_rsp_valid && dma_rsp_ready)) else begin
        other_errors++;
        $display("%0t ns: context popped without a dma transfer", $time);
      end
      if (eg_done) begin
        done_seen++;
        assert (exp_alu.size() == 0 && exp_mul.size() == 0) else begin
          other_errors++;
          $display("%0t ns: eg_done raised while atoms were still pending", $time);
        end
      end
    end
  end

  always @(posedge nvdla_core_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // consumers stall about 30% of cycles
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      alu_ready = ($urandom_range(0, 9) >= 3);
      mul_ready = ($urandom_range(0, 9) >= 3);
    end
  end

  // ======================================================================
  // stimulus
  // ======================================================================
  // starts and ends on a falling edge
  task automatic send_word(input mem_word_t data, input atom_mask_t mask, input bit req_last);
    bit taken;
    dma_rsp_data  = data;
    dma_rsp_mask  = mask;
    dma_rsp_valid = 1'b1;
    taken = 1'b0;
    while (!taken) begin
      @(posedge nvdla_core_clk);
      taken = dma_rsp_valid && dma_rsp_ready;
    end
    words_sent++;
    assert (cq_ready === req_last) else begin
      value_errors++;
      $display("[FAIL] %0t ns cq_ready expected %0b got %0b", $time, req_last, cq_ready);
    end
    @(negedge nvdla_core_clk);
    dma_rsp_valid = 1'b0;
  endtask

  // one layer with its atom count programmed to match the random words
  task automatic run_layer(input data_use_e use_sel, input data_size_e size_sel);
    mem_word_t  w_data[$];
    atom_mask_t w_mask[$];
    bit         w_last[$];
    int         w_size[$];
    mem_word_t  word;
    atom_mask_t mask;
    int         nbeats;
    int         req_atoms;
    int         stream_atoms;
    stream_atoms = 0;
    for (int r = 0; r < N_REQS; r++) begin
      nbeats    = $urandom_range(1, MAX_BEATS);
      req_atoms = 0;
      for (int b = 0; b < nbeats; b++) begin
        for (int i = 0; i < `RDMA_EG_ATOMS; i++) word[AW*i +: AW] = $urandom;
        mask = atom_mask_t'($urandom_range(1, 15));
        // atom 0 of the first word keeps both streams non-empty
        if (w_mask.size() == 0) mask[0] = 1'b1;
        for (int i = 0; i < `RDMA_EG_ATOMS; i++) begin
          if (mask[i] && (use_sel != both || i % 2 == 0)) stream_atoms++;
        end
        req_atoms += $countones(mask);
        w_data.push_back(word);
        w_mask.push_back(mask);
        w_last.push_back(b == nbeats - 1);
      end
      repeat (nbeats) w_size.push_back(req_atoms - 1);
    end
    data_use    = use_sel;
    data_size   = size_sel;
    layer_atoms = layer_cnt_t'(stream_atoms - 1);
    op_load     = 1'b1;
    alu_cnt     = 0;
    mul_cnt     = 0;
    foreach (w_data[n]) push_word(w_data[n], w_mask[n]);
    @(negedge nvdla_core_clk);
    op_load = 1'b0;
    // first word waits two cycles for its context entry
    dma_rsp_data  = w_data[0];
    dma_rsp_mask  = w_mask[0];
    dma_rsp_valid = 1'b1;
    cq_size       = CQ_W'(w_size[0]);
    repeat (2) @(negedge nvdla_core_clk);
    cq_valid = 1'b1;
    foreach (w_data[n]) begin
      cq_size     = CQ_W'(w_size[n]);
      cq_cube_end = (n == w_data.size() - 1);
      send_word(w_data[n], w_mask[n], w_last[n]);
    end
    cq_valid = 1'b0;
    while (!eg_done) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
  endtask

  initial begin
    void'($urandom(32'h4b3fc9d1));
    nvdla_core_clk  = 1'b0;
    nvdla_core_rstn = 1'b0;
    dma_rsp_data    = '0;
    dma_rsp_mask    = '0;
    dma_rsp_valid   = 1'b0;
    cq_size         = '0;
    cq_cube_end     = 1'b0;
    cq_valid        = 1'b0;
    alu_ready       = 1'b0;
    mul_ready       = 1'b0;
    data_use        = mul_only;
    data_size       = size_1byte;
    layer_atoms     = '0;
    op_load         = 1'b0;
    repeat (4) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    // single stream forwarding at both sizes
    run_layer(mul_only, size_1byte);
    run_layer(mul_only, size_2byte);
    run_layer(alu_only, size_1byte);
    run_layer(alu_only, size_2byte);
    // element split across both streams
    run_layer(both, size_1byte);
    run_layer(both, size_2byte);
    run_layer(both, size_1byte);
    run_layer(alu_only, size_1byte);
    repeat (4) @(negedge nvdla_core_clk);
    assert (pops_seen == words_sent) else begin
      other_errors++;
      $display("credit pops %0d do not match %0d dma transfers", pops_seen, words_sent);
    end
    assert (done_seen == N_LAYERS) else begin
      other_errors++;
      $display("saw %0d eg_done pulses for %0d layers", done_seen, N_LAYERS);
    end
    sva_errors = sdp_rdma_eg_inst.u_sva.fail_count;
    $display("errors: %0d value, %0d other, %0d assertion",
             value_errors, other_errors, sva_errors);
    if (value_errors + other_errors + sva_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+src
src/sdp_rdma_eg_pkg.sv
src/rdma_eg_ctrl.sv
src/rdma_eg_route.sv
src/rdma_eg_stream.sv
src/sdp_rdma_eg.sv
bench/sdp_rdma_eg_sva.sv
bench/sdp_rdma_eg_tb.sv

/* Makefile */
SIM      = verilator
TOP      = sdp_rdma_eg_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG = *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
